/* common/video_defines.svh */
// raster timing constants for the spectrum-style video block
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// ticks per line and lines per frame
`define VID_HPERIOD     9'd448
`define VID_VPERIOD     9'd320

// hsync, repeated at half line
`define VID_HSYNC_BEG   9'd5
`define VID_HSYNC_END   9'd31

`define VID_HBLNK_END   9'd88

`define VID_VSYNC_BEG   9'd8
`define VID_VSYNC_END   9'd11

`define VID_VBLNK_END   9'd32

// interrupt position in the frame
`define VID_HINT_BEG    9'd2
`define VID_VINT_BEG    9'd0

// clk cycles per pixel tick
`define VID_TICK_DIV    8

`endif

/* common/video_timing_pkg.sv */
// raster timing types: tick position, line number and clock phase
`default_nettype none

package video_timing_pkg;

	// horizontal position in ticks
	typedef logic [8:0] hcount_t;

	// line number within the frame
	typedef logic [8:0] vcount_t;

	// clk phase within one tick
	typedef logic [2:0] phase_t;

endpackage

`default_nettype wire

/* common/video_fetch_pkg.sv */
// video fetch types: sequencer states, memory address, data and colour
`default_nettype none

package video_fetch_pkg;

	typedef enum logic [1:0] {IDLE, RD_PIX, RD_ATTR, HOLD} fetch_state_t;

	typedef logic [12:0] vaddr_t;
	typedef logic [7:0] vbyte_t;

	// bright, g, r, b
	typedef logic [3:0] colour_t;

endpackage

`default_nettype wire

/* verilog/clk_phase_gen.sv */
// divides clk into pixel ticks and decodes the c0 and c6 phase strobes
`default_nettype none
`include "video_defines.svh"

module clk_phase_gen (
	input wire logic clk,
	input wire logic arst_n,
	output logic c0,
	output logic c6
);

	video_timing_pkg::phase_t phase;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			phase <= '0;
		else if (phase == video_timing_pkg::phase_t'(`VID_TICK_DIV - 1))
			phase <= '0;
		else
			phase <= phase + 3'd1;
	end

	assign c0 = phase == 3'd0;
	assign c6 = phase == 3'd6;

endmodule

`default_nettype wire

/* video_sync/video_sync.sv */
// line and frame counters with syncs, blanking and window strobes
`default_nettype none
`include "video_defines.svh"

module video_sync (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic c0,
	input wire logic c6,
	input wire video_timing_pkg::hcount_t hpix_beg,
	input wire video_timing_pkg::hcount_t hpix_end,
	input wire video_timing_pkg::hcount_t go_beg,
	input wire video_timing_pkg::hcount_t go_end,
	input wire video_timing_pkg::vcount_t vpix_beg,
	input wire video_timing_pkg::vcount_t vpix_end,
	output logic hsync,
	output logic vsync,
	output logic csync,
	output logic blank,
	output logic hvpix,
	output logic video_go,
	output logic pix_start,
	output logic line_start,
	output logic frame_start,
	output logic int_start,
	output video_timing_pkg::hcount_t hcount,
	output video_timing_pkg::vcount_t vcount
);

	logic line_end;
	logic frame_end;
	logic hs;
	logic vs;
	logic hb;
	logic vb;
	logic hpix;
	logic vpix;

	assign line_end = hcount == `VID_HPERIOD - 9'd1;
	assign frame_end = vcount == `VID_VPERIOD - 9'd1;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hcount <= '0;
			vcount <= '0;
		end
		else if (c6)
		begin
			if (line_end)
			begin
				hcount <= '0;
				if (frame_end)
					vcount <= '0;
				else
					vcount <= vcount + 9'd1;
			end
			else
				hcount <= hcount + 9'd1;
		end
	end

	// short hsync, once per half line
	assign hs = ((hcount >= `VID_HSYNC_BEG) && (hcount < `VID_HSYNC_END)) ||
		((hcount >= `VID_HSYNC_BEG + `VID_HPERIOD / 2) &&
		(hcount < `VID_HSYNC_END + `VID_HPERIOD / 2));
	assign vs = (vcount >= `VID_VSYNC_BEG) && (vcount < `VID_VSYNC_END);

	assign hb = hcount < `VID_HBLNK_END;
	assign vb = vcount < `VID_VBLNK_END;
	assign blank = hb || vb;

	assign hpix = (hcount >= hpix_beg) && (hcount < hpix_end);
	assign vpix = (vcount >= vpix_beg) && (vcount < vpix_end);
	assign hvpix = hpix && vpix;

	// fetch runs one cell ahead of the pixel window
	assign video_go = (hcount >= go_beg) && (hcount < go_end) && vpix;

	assign pix_start = hcount == hpix_beg - 9'd1;
	assign line_start = line_end;
	assign frame_start = line_end && frame_end;

	// single-clk pulse for the cpu interrupt
	assign int_start = (hcount == `VID_HINT_BEG) && (vcount == `VID_VINT_BEG) && c0;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hsync <= 1'b1;
			vsync <= 1'b1;
			csync <= 1'b1;
		end
		else
		begin
			hsync <= ~hs;
			vsync <= ~vs;
			csync <= ~(hs ^ vs);
		end
	end

endmodule

`default_nettype wire

/* video_fetch/video_fetch_fsm.sv */
// per-cell sequencer reading the bitmap byte and then the attribute byte
`default_nettype none

module video_fetch_fsm (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic c6,
	input wire logic video_go,
	input wire logic line_start,
	input wire video_fetch_pkg::vbyte_t vram_data,
	output logic rd_pix,
	output logic rd_attr,
	output video_fetch_pkg::vbyte_t pix_byte,
	output video_fetch_pkg::vbyte_t attr_byte
);

	video_fetch_pkg::fetch_state_t state;
	logic [2:0] hold_cnt;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= video_fetch_pkg::IDLE;
			hold_cnt <= '0;
		end
		else if (c6)
		begin
			if (line_start)
				state <= video_fetch_pkg::IDLE;
			else
			begin
				case (state)
					video_fetch_pkg::IDLE:
						if (video_go)
							state <= video_fetch_pkg::RD_PIX;
					video_fetch_pkg::RD_PIX:
						state <= video_fetch_pkg::RD_ATTR;
					video_fetch_pkg::RD_ATTR:
					begin
						state <= video_fetch_pkg::HOLD;
						hold_cnt <= '0;
					end
					video_fetch_pkg::HOLD:
						// six ticks fill out the eight-tick cell
						if (hold_cnt == 3'd5)
							state <= video_go ? video_fetch_pkg::RD_PIX : video_fetch_pkg::IDLE;
						else
							hold_cnt <= hold_cnt + 3'd1;
					default:
						state <= video_fetch_pkg::IDLE;
				endcase
			end
		end
	end

	// data arrives one tick after each read strobe
	always_ff @(posedge clk)
	begin
		if (c6)
		begin
			if (state == video_fetch_pkg::RD_ATTR)
				pix_byte <= vram_data;
			if (state == video_fetch_pkg::HOLD && hold_cnt == 3'd0)
				attr_byte <= vram_data;
		end
	end

	assign rd_pix = state == video_fetch_pkg::RD_PIX;
	assign rd_attr = state == video_fetch_pkg::RD_ATTR;

endmodule

`default_nettype wire

/* video_fetch/video_addr_gen.sv */
// spectrum screen address generation for bitmap and attribute reads
`default_nettype none

module video_addr_gen (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic c6,
	input wire logic rd_pix,
	input wire logic rd_attr,
	input wire logic line_start,
	input wire video_timing_pkg::vcount_t vcount,
	input wire video_timing_pkg::vcount_t vpix_beg,
	output video_fetch_pkg::vaddr_t vram_addr
);

	localparam video_fetch_pkg::vaddr_t ATTR_BASE = 13'h1800;

	logic [4:0] col;
	video_timing_pkg::vcount_t y;
	video_fetch_pkg::vaddr_t pix_addr;
	video_fetch_pkg::vaddr_t attr_addr;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			col <= '0;
		else if (c6)
		begin
			if (line_start)
				col <= '0;
			else if (rd_attr)
				col <= col + 5'd1;
		end
	end

	// screen row within the window
	assign y = vcount - vpix_beg;

	// third, char row, then pixel row swapped in
	assign pix_addr = {y[7:6], y[2:0], y[5:3], col};
	assign attr_addr = ATTR_BASE + {3'b000, y[7:3], col};

	assign vram_addr = rd_pix ? pix_addr : attr_addr;

endmodule

`default_nettype wire

/* video_fetch/pixel_shifter.sv */
// cell shifter and ink, paper or border colour select
`default_nettype none

module pixel_shifter (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic c6,
	input wire logic pix_start,
	input wire logic hvpix,
	input wire logic blank,
	input wire video_timing_pkg::hcount_t hcount,
	input wire video_timing_pkg::hcount_t hpix_beg,
	input wire video_fetch_pkg::vbyte_t pix_byte,
	input wire video_fetch_pkg::vbyte_t attr_byte,
	input wire video_fetch_pkg::colour_t border,
	output video_fetch_pkg::colour_t colour
);

	video_fetch_pkg::vbyte_t shift;
	video_fetch_pkg::vbyte_t attr;
	video_timing_pkg::hcount_t hoff;
	logic load;

	// load on the last tick of each cell, so the new msb shows next tick
	assign hoff = hcount - hpix_beg;
	assign load = pix_start || (hvpix && hoff[2:0] == 3'd7);

	always_ff @(posedge clk)
	begin
		if (c6)
		begin
			if (load)
			begin
				shift <= pix_byte;
				attr <= attr_byte;
			end
			else
				shift <= {shift[6:0], 1'b0};
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			colour <= '0;
		else if (blank)
			colour <= '0;
		else if (!hvpix)
			colour <= border;
		else if (shift[7])
			colour <= {attr[6], attr[2:0]};
		else
			colour <= {attr[6], attr[5:3]};
	end

endmodule

`default_nettype wire

/* verilog/video_top.sv */
// video raster top: tick phases, sync timing, fetch and pixel output
`default_nettype none

module video_top (
	input wire logic clk,
	input wire logic arst_n,
	input wire video_timing_pkg::hcount_t hpix_beg,
	input wire video_timing_pkg::hcount_t hpix_end,
	input wire video_timing_pkg::hcount_t go_beg,
	input wire video_timing_pkg::hcount_t go_end,
	input wire video_timing_pkg::vcount_t vpix_beg,
	input wire video_timing_pkg::vcount_t vpix_end,
	input wire video_fetch_pkg::colour_t border,
	input wire video_fetch_pkg::vbyte_t vram_data,
	output video_fetch_pkg::vaddr_t vram_addr,
	output logic vram_rd,
	output logic hsync,
	output logic vsync,
	output logic csync,
	output logic blank,
	output logic int_start,
	output video_fetch_pkg::colour_t colour
);

	logic c0;
	logic c6;
	logic hvpix;
	logic video_go;
	logic pix_start;
	logic line_start;
	logic rd_pix;
	logic rd_attr;
	video_timing_pkg::hcount_t hcount;
	video_timing_pkg::vcount_t vcount;
	video_fetch_pkg::vbyte_t pix_byte;
	video_fetch_pkg::vbyte_t attr_byte;

	clk_phase_gen u_phase (
		.clk    (clk),
		.arst_n (arst_n),
		.c0     (c0),
		.c6     (c6)
	);

	video_sync u_sync (
		.clk         (clk),
		.arst_n      (arst_n),
		.c0          (c0),
		.c6          (c6),
		.hpix_beg    (hpix_beg),
		.hpix_end    (hpix_end),
		.go_beg      (go_beg),
		.go_end      (go_end),
		.vpix_beg    (vpix_beg),
		.vpix_end    (vpix_end),
		.hsync       (hsync),
		.vsync       (vsync),
		.csync       (csync),
		.blank       (blank),
		.hvpix       (hvpix),
		.video_go    (video_go),
		.pix_start   (pix_start),
		.line_start  (line_start),
		.frame_start (),
		.int_start   (int_start),
		.hcount      (hcount),
		.vcount      (vcount)
	);

	video_fetch_fsm u_fetch (
		.clk        (clk),
		.arst_n     (arst_n),
		.c6         (c6),
		.video_go   (video_go),
		.line_start (line_start),
		.vram_data  (vram_data),
		.rd_pix     (rd_pix),
		.rd_attr    (rd_attr),
		.pix_byte   (pix_byte),
		.attr_byte  (attr_byte)
	);

	video_addr_gen u_addr (
		.clk        (clk),
		.arst_n     (arst_n),
		.c6         (c6),
		.rd_pix     (rd_pix),
		.rd_attr    (rd_attr),
		.line_start (line_start),
		.vcount     (vcount),
		.vpix_beg   (vpix_beg),
		.vram_addr  (vram_addr)
	);

	pixel_shifter u_shifter (
		.clk       (clk),
		.arst_n    (arst_n),
		.c6        (c6),
		.pix_start (pix_start),
		.hvpix     (hvpix),
		.blank     (blank),
		.hcount    (hcount),
		.hpix_beg  (hpix_beg),
		.pix_byte  (pix_byte),
		.attr_byte (attr_byte),
		.border    (border),
		.colour    (colour)
	);

	assign vram_rd = rd_pix || rd_attr;

endmodule

`default_nettype wire

/* bench/video_tb.sv */
// testbench checking sync timing, fetch addresses and pixel colour of the video raster top
`default_nettype none
`include "video_defines.svh"

module video_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TICK_CLKS = `VID_TICK_DIV;
	localparam int LINE_TICKS = `VID_HPERIOD;
	localparam int FRAME_LINES = `VID_VPERIOD;
	localparam int FRAME_CLKS = FRAME_LINES * LINE_TICKS * TICK_CLKS;
	localparam int CYCLE_LIMIT = FRAME_CLKS * 22 / 10;
	localparam int HSYNC_GAP = 224 * 8;
	localparam int HSYNC_LOW = 26 * 8;
	localparam int VSYNC_LOW = 3 * 448 * 8;
	localparam int HPIX_BEG = 104;
	localparam int HPIX_END = 360;
	localparam int VPIX_BEG = 64;
	localparam int VPIX_END = 256;

	logic clk;
	logic arst_n;
	video_timing_pkg::hcount_t hpix_beg;
	video_timing_pkg::hcount_t hpix_end;
	video_timing_pkg::hcount_t go_beg;
	video_timing_pkg::hcount_t go_end;
	video_timing_pkg::vcount_t vpix_beg;
	video_timing_pkg::vcount_t vpix_end;
	video_fetch_pkg::colour_t border;
	video_fetch_pkg::vbyte_t vram_data;
	video_fetch_pkg::vaddr_t vram_addr;
	logic vram_rd;
	logic hsync;
	logic vsync;
	logic csync;
	logic blank;
	logic int_start;
	video_fetch_pkg::colour_t colour;

	logic [7:0] mem [0:8191];
	integer seed;
	int cycle = 0;
	int ph = 0;
	int h = 0;
	int v = 0;
	int hp = 0;
	int vp = 0;
	int reads = 0;
	int vfalls = 0;
	int last_hfall = -1;
	int last_vfall = -1;
	int pend_addr = 0;
	bit rd_pending = 0;
	bit aligned = 0;
	logic hsync_q = 1'b1;
	logic vsync_q = 1'b1;

	video_top uut (
		.clk       (clk),
		.arst_n    (arst_n),
		.hpix_beg  (hpix_beg),
		.hpix_end  (hpix_end),
		.go_beg    (go_beg),
		.go_end    (go_end),
		.vpix_beg  (vpix_beg),
		.vpix_end  (vpix_end),
		.border    (border),
		.vram_data (vram_data),
		.vram_addr (vram_addr),
		.vram_rd   (vram_rd),
		.hsync     (hsync),
		.vsync     (vsync),
		.csync     (csync),
		.blank     (blank),
		.int_start (int_start),
		.colour    (colour)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stop_on_failure(input string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
			stop_on_failure($sformatf("** Error at %0t: %s is %0h, expected %0h",
				$time, name, got, exp));
	endtask

	function automatic bit hsync_active(input int hpos);
		return (hpos >= `VID_HSYNC_BEG && hpos < `VID_HSYNC_END) ||
			(hpos >= `VID_HSYNC_BEG + LINE_TICKS / 2 && hpos < `VID_HSYNC_END + LINE_TICKS / 2);
	endfunction

	function automatic bit vsync_active(input int vpos);
		return vpos >= `VID_VSYNC_BEG && vpos < `VID_VSYNC_END;
	endfunction

	// screen thirds of 2 KB, then pixel row, then character row
	function automatic int bitmap_addr(input int y, input int col);
		return (y / 64) * 2048 + (y % 8) * 256 + ((y / 8) % 8) * 32 + col;
	endfunction

	function automatic int attr_addr(input int y, input int col);
		return 'h1800 + (y / 8) * 32 + col;
	endfunction

	function automatic logic [3:0] expected_colour(input int hpos, input int vpos,
		input logic [3:0] bcol);
		int x;
		logic [7:0] bits;
		logic [7:0] attr;
		if (hpos < `VID_HBLNK_END || vpos < `VID_VBLNK_END)
			return 4'h0;
		if (hpos < HPIX_BEG || hpos >= HPIX_END || vpos < VPIX_BEG || vpos >= VPIX_END)
			return bcol;
		x = hpos - HPIX_BEG;
		bits = mem[bitmap_addr(vpos - VPIX_BEG, x / 8)];
		attr = mem[attr_addr(vpos - VPIX_BEG, x / 8)];
		// msb is the leftmost pixel of the cell
		if (bits[7 - x % 8])
			return {attr[6], attr[2:0]};
		return {attr[6], attr[5:3]};
	endfunction

	task automatic check_line_reads();
		if (v >= VPIX_BEG && v < VPIX_END)
			check_value("vram_rd count", reads, 64);
		reads = 0;
	endtask

	// position before and after the last clk edge
	task automatic advance_position();
		hp = h;
		vp = v;
		if (ph == 6)
		begin
			if (h == LINE_TICKS - 1)
			begin
				check_line_reads();
				h = 0;
				v = (v == FRAME_LINES - 1) ? 0 : v + 1;
			end
			else
				h = h + 1;
		end
		ph = (ph + 1) % TICK_CLKS;
	endtask

	task automatic check_read();
		int exp_addr;
		if (v < VPIX_BEG || v >= VPIX_END)
			stop_on_failure($sformatf("vram_rd went high on line %0d, outside the window", v));
		if (reads % 2 == 0)
			exp_addr = bitmap_addr(v - VPIX_BEG, reads / 2);
		else
			exp_addr = attr_addr(v - VPIX_BEG, reads / 2);
		check_value("vram_addr", vram_addr, exp_addr);
		reads++;
	endtask

	task automatic check_sync_edges();
		if (hsync_q && !hsync)
		begin
			if (last_hfall >= 0)
				check_value("hsync fall spacing", cycle - last_hfall, HSYNC_GAP);
			last_hfall = cycle;
		end
		if (!hsync_q && hsync && last_hfall >= 0)
			check_value("hsync low width", cycle - last_hfall, HSYNC_LOW);
		if (vsync_q && !vsync)
		begin
			check_value("vsync fall spacing", cycle - last_vfall, FRAME_CLKS);
			last_vfall = cycle;
			vfalls++;
		end
		if (!vsync_q && vsync)
			check_value("vsync low width", cycle - last_vfall, VSYNC_LOW);
	endtask

	task automatic check_outputs();
		check_value("hsync", hsync, !hsync_active(hp));
		check_value("vsync", vsync, !vsync_active(vp));
		check_value("csync", csync, !(hsync_active(hp) ^ vsync_active(vp)));
		check_value("blank", blank, h < `VID_HBLNK_END || v < `VID_VBLNK_END);
		check_value("int_start", int_start,
			ph == 0 && h == `VID_HINT_BEG && v == `VID_VINT_BEG);
		check_value("colour", colour, expected_colour(hp, vp, border));
		if (ph == 7 && vram_rd)
			check_read();
	endtask

	// one tick of read latency
	task automatic answer_memory();
		if (ph == 7)
		begin
			if (rd_pending)
				vram_data = mem[pend_addr];
			rd_pending = vram_rd;
			pend_addr = vram_addr;
		end
	endtask

	initial
	begin
		seed = 32'h5c7a;
		arst_n = 1'b0;
		hpix_beg = 9'd104;
		hpix_end = 9'd360;
		go_beg = 9'd96;
		go_end = 9'd352;
		vpix_beg = 9'd64;
		vpix_end = 9'd256;
		vram_data = '0;
		border = 4'($random(seed));
		for (int a = 0; a < 8192; a++)
			mem[a] = 8'($random(seed) ^ a ^ (a >> 8));
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		while (vfalls < 2)
		begin
			@(negedge clk);
			cycle++;
			if (cycle > CYCLE_LIMIT)
				stop_on_failure("timeout: the second vsync did not come within 2.2 frames");
			if (aligned)
			begin
				advance_position();
				check_sync_edges();
				check_outputs();
				answer_memory();
			end
			else if (!vsync)
			begin
				// first vsync fall marks tick 0 of line 8
				aligned = 1;
				ph = 0;
				h = 0;
				v = `VID_VSYNC_BEG;
				hp = h;
				vp = v;
				last_vfall = cycle;
				vfalls = 1;
				check_outputs();
			end
			hsync_q = hsync;
			vsync_q = vsync;
			if (aligned && ph == 3 && h == 0)
				border = 4'($random(seed));
		end
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+common
common/video_timing_pkg.sv
common/video_fetch_pkg.sv
verilog/clk_phase_gen.sv
video_sync/video_sync.sv
video_fetch/video_fetch_fsm.sv
video_fetch/video_addr_gen.sv
video_fetch/pixel_shifter.sv
verilog/video_top.sv
bench/video_tb.sv

/* Bender.yml */
package:
  name: video_raster

sources:
  - include_dirs:
      - common
    files:
      - common/video_timing_pkg.sv
      - common/video_fetch_pkg.sv
      - verilog/clk_phase_gen.sv
      - video_sync/video_sync.sv
      - video_fetch/video_fetch_fsm.sv
      - video_fetch/video_addr_gen.sv
      - video_fetch/pixel_shifter.sv
      - verilog/video_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - bench/video_tb.sv
